// File: source/cpu_pkg.sv
package cpu_pkg;

  localparam int word_width = 32; // Bus, register and memory word width.
  localparam int ctrl_data_width = 6; // Constant field of the control word.
  localparam int uop_count_width = 5; // Micro-op counter width.
  localparam int mem_words = 256; // Word memory depth, byte address bits 9:2.
  localparam int reg_pc = 31; // r31 holds the program counter.

  // Opcode field, bits 31:26 of the opword.
  typedef enum logic [5:0] {
    op_reset = 6'd0, // Internal, clears the PC.
    op_fetch = 6'd1, // Internal, loads the next opword.
    op_lhu = 6'd2, // rD = zeroext(I).
    op_addu = 6'd3, // rD = rS + zeroext(I).
    op_add3 = 6'd4, // rD = rA + rB.
    op_sw = 6'd5, // mem[rD] = rS.
    op_or3 = 6'd6, // rD = rA | rB.
    op_lh = 6'd7 // rD = signext(I).
  } opcode_e;

  typedef enum logic [1:0] {
    reg_sel_opword0 = 2'd0, // rD, opword bits 25:21.
    reg_sel_opword1 = 2'd1, // Opword bits 20:16.
    reg_sel_opword2 = 2'd2, // Opword bits 15:11.
    reg_sel_control = 2'd3 // Index taken from ctrl_data.
  } reg_sel_e;

  // Bus sources, code 7 is left free.
  typedef enum logic [3:0] {
    out_none = 4'd0,
    out_reg = 4'd1,
    out_tmp0 = 4'd2,
    out_tmp1 = 4'd3,
    out_mmu = 4'd4,
    out_mlu = 4'd5,
    out_shifter = 4'd6,
    out_ctrl_data = 4'd8,
    out_opword_immediate = 4'd9
  } out_plane_e;

  // Bus sinks.
  typedef enum logic [2:0] {
    in_none = 3'd0,
    in_reg = 3'd1,
    in_tmp0 = 3'd2,
    in_tmp1 = 3'd3,
    in_mmu = 3'd4,
    in_opword = 3'd5,
    in_opcode = 3'd6
  } in_plane_e;

  typedef enum logic [2:0] {
    mlu_add = 3'd0,
    mlu_or = 3'd1
  } mlu_op_e;

  typedef enum logic [1:0] {
    shift_pass = 2'd0,
    shift_signext16 = 2'd1
  } shifter_op_e;

  typedef enum logic {
    opcode_from_opword = 1'b0,
    opcode_from_bus = 1'b1
  } opcode_sel_e;

endpackage

// File: source/microcode.sv
`timescale 1ns/100ps

module microcode
  import cpu_pkg::*;
(
  input opcode_e opcode,
  input logic [uop_count_width-1:0] uop_count,
  output logic [ctrl_data_width-1:0] ctrl_data,
  output reg_sel_e reg_sel,
  output out_plane_e out_plane,
  output in_plane_e in_plane,
  output logic uop_reset,
  output mlu_op_e mlu_op,
  output shifter_op_e shifter_op,
  output opcode_sel_e opcode_sel
);

  logic go_fetch; // Step returns to the fetch opcode.

  always_comb begin
    ctrl_data = '0; // Idle control word.
    reg_sel = reg_sel_opword0;
    out_plane = out_none;
    in_plane = in_none;
    uop_reset = 1'b0;
    mlu_op = mlu_add;
    shifter_op = shift_pass;
    opcode_sel = opcode_from_opword;
    go_fetch = 1'b0;
    case (opcode)
      op_reset: begin
        case (uop_count)
          5'd0: begin
            ctrl_data = ctrl_data_width'(reg_pc); // PC <= 0, bus idles at zero.
            reg_sel = reg_sel_control;
            in_plane = in_reg;
          end
          5'd1: go_fetch = 1'b1;
          default: ;
        endcase
      end
      op_fetch: begin
        case (uop_count)
          5'd0: begin
            ctrl_data = ctrl_data_width'(reg_pc); // Address memory with the PC.
            reg_sel = reg_sel_control;
            out_plane = out_reg;
            in_plane = in_tmp0;
          end
          5'd1: begin
            out_plane = out_mmu; // Load the opword.
            in_plane = in_opword;
          end
          5'd2: begin
            ctrl_data = ctrl_data_width'(4); // PC increment.
            out_plane = out_ctrl_data;
            in_plane = in_tmp1;
          end
          5'd3: begin
            ctrl_data = ctrl_data_width'(reg_pc); // PC <= PC + 4.
            reg_sel = reg_sel_control;
            out_plane = out_mlu;
            in_plane = in_reg;
            mlu_op = mlu_add;
          end
          5'd4: begin
            in_plane = in_opcode; // Decode from the opword.
            uop_reset = 1'b1;
            opcode_sel = opcode_from_opword;
          end
          default: ;
        endcase
      end
      op_lh: begin
        case (uop_count)
          5'd0: begin
            out_plane = out_opword_immediate; // Immediate into tmp0.
            in_plane = in_tmp0;
          end
          5'd1: begin
            reg_sel = reg_sel_opword0; // rD <= signext16(tmp0).
            out_plane = out_shifter;
            shifter_op = shift_signext16;
            in_plane = in_reg;
          end
          5'd2: go_fetch = 1'b1;
          default: ;
        endcase
      end
      op_lhu: begin
        case (uop_count)
          5'd0: begin
            reg_sel = reg_sel_opword0; // Zero-extended immediate into rD.
            out_plane = out_opword_immediate;
            in_plane = in_reg;
          end
          5'd1: go_fetch = 1'b1;
          default: ;
        endcase
      end
      op_sw: begin
        case (uop_count)
          5'd0: begin
            reg_sel = reg_sel_opword0; // Store address from rD.
            out_plane = out_reg;
            in_plane = in_tmp0;
          end
          5'd1: begin
            reg_sel = reg_sel_opword1; // Store data from rS.
            out_plane = out_reg;
            in_plane = in_mmu;
          end
          5'd2: go_fetch = 1'b1;
          default: ;
        endcase
      end
      op_addu, op_add3, op_or3: begin
        case (uop_count)
          5'd0: begin
            reg_sel = reg_sel_opword1; // First operand.
            out_plane = out_reg;
            in_plane = in_tmp0;
          end
          5'd1: begin
            reg_sel = reg_sel_opword2; // Second register, unless addu.
            out_plane = (opcode == op_addu) ? out_opword_immediate : out_reg;
            in_plane = in_tmp1;
          end
          5'd2: begin
            reg_sel = reg_sel_opword0; // Result into rD.
            out_plane = out_mlu;
            in_plane = in_reg;
            mlu_op = (opcode == op_or3) ? mlu_or : mlu_add;
          end
          5'd3: go_fetch = 1'b1;
          default: ;
        endcase
      end
      default: go_fetch = (uop_count == '0); // Undefined opcode is skipped.
    endcase
    if (go_fetch) begin
      ctrl_data = ctrl_data_width'(op_fetch); // Opcode <= fetch, counter <= 0.
      out_plane = out_ctrl_data;
      in_plane = in_opcode;
      uop_reset = 1'b1;
      opcode_sel = opcode_from_bus;
    end
  end

  // Every latching sink needs a driven bus, except the PC clear at reset.
  always_comb begin
    if (!(opcode == op_reset && uop_count == '0)) begin
      assert final (!(out_plane == out_none &&
                      in_plane inside {in_reg, in_tmp0, in_tmp1, in_mmu}))
        else $error("Sink latches an undriven bus, opcode %0d uop %0d", opcode, uop_count);
    end
  end

endmodule

// File: source/control_logic.sv
`timescale 1ns/100ps

module control_logic
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic booted,
  input logic [word_width-1:0] bus,
  input in_plane_e in_plane,
  input logic uop_reset,
  input opcode_sel_e opcode_sel,
  output opcode_e opcode,
  output logic [uop_count_width-1:0] uop_count,
  output logic [word_width-1:0] opword
);

  opcode_e next_opcode; // Opcode source chosen by opcode_sel.

  always_comb begin
    if (opcode_sel == opcode_from_bus) begin
      next_opcode = opcode_e'(bus[5:0]); // Constant from the control word.
    end else begin
      next_opcode = opcode_e'(opword[31:26]); // Decoded instruction.
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !booted) begin
      opcode <= op_reset; // Rerun the reset sequence once booted.
      uop_count <= '0;
    end else begin
      if (in_plane == in_opcode) begin
        opcode <= next_opcode;
      end
      if (uop_reset) begin
        uop_count <= '0;
      end else begin
        uop_count <= uop_count + 1'b1; // One micro-op per cycle.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_plane == in_opword) begin
      opword <= bus; // Instruction word from memory.
    end
  end

  // The longest sequence is fetch with five steps.
  assert property (@(posedge clk) disable iff (rst || !booted) uop_count < 5'd5)
    else $error("Micro-op counter ran past the end of a sequence");

endmodule

// File: source/register_file.sv
`timescale 1ns/100ps

module register_file
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input reg_sel_e reg_sel,
  input logic [ctrl_data_width-1:0] ctrl_data,
  input logic [word_width-1:0] opword,
  input in_plane_e in_plane,
  input logic [word_width-1:0] bus,
  output logic [word_width-1:0] rd_data
);

  logic [word_width-1:0] regs [32]; // r31 is the PC.
  logic [4:0] index;

  always_comb begin
    case (reg_sel)
      reg_sel_opword0: index = opword[25:21];
      reg_sel_opword1: index = opword[20:16];
      reg_sel_opword2: index = opword[15:11];
      default: index = ctrl_data[4:0]; // Fixed register from microcode.
    endcase
  end

  assign rd_data = regs[index]; // Combinational read.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (in_plane == in_reg) begin
      regs[index] <= bus;
    end
  end

endmodule

// File: source/datapath.sv
`timescale 1ns/100ps

module datapath
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input out_plane_e out_plane,
  input in_plane_e in_plane,
  input mlu_op_e mlu_op,
  input shifter_op_e shifter_op,
  input logic [ctrl_data_width-1:0] ctrl_data,
  input logic [word_width-1:0] opword,
  input logic [word_width-1:0] rd_data,
  input logic [word_width-1:0] mem_rdata,
  output logic [word_width-1:0] bus,
  output logic [word_width-1:0] tmp0
);

  logic [word_width-1:0] tmp1;
  logic [word_width-1:0] mlu_out;
  logic [word_width-1:0] shifter_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      tmp0 <= '0;
      tmp1 <= '0;
    end else begin
      if (in_plane == in_tmp0) begin
        tmp0 <= bus; // Also the memory address.
      end
      if (in_plane == in_tmp1) begin
        tmp1 <= bus;
      end
    end
  end

  always_comb begin
    case (mlu_op)
      mlu_or: mlu_out = tmp0 | tmp1;
      default: mlu_out = tmp0 + tmp1; // Add, carry out dropped.
    endcase
  end

  always_comb begin
    case (shifter_op)
      shift_signext16: shifter_out = {{16{tmp0[15]}}, tmp0[15:0]};
      default: shifter_out = tmp0; // Pass.
    endcase
  end

  // One source drives the bus per micro-op.
  always_comb begin
    case (out_plane)
      out_reg: bus = rd_data;
      out_tmp0: bus = tmp0;
      out_tmp1: bus = tmp1;
      out_mmu: bus = mem_rdata;
      out_mlu: bus = mlu_out;
      out_shifter: bus = shifter_out;
      out_ctrl_data: bus = word_width'(ctrl_data); // Zero-extended.
      out_opword_immediate: bus = word_width'(opword[15:0]); // Zero-extended.
      default: bus = '0; // Idle bus reads as zero.
    endcase
  end

endmodule

// File: source/memory.sv
`timescale 1ns/100ps

module memory
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic boot_we,
  input logic [$clog2(mem_words)-1:0] boot_addr,
  input logic [word_width-1:0] boot_data,
  input logic [word_width-1:0] tmp0,
  input logic [word_width-1:0] bus,
  input in_plane_e in_plane,
  output logic [word_width-1:0] mem_rdata,
  output logic store_valid,
  output logic [word_width-1:0] store_addr,
  output logic [word_width-1:0] store_data
);

  logic [word_width-1:0] mem [mem_words];
  logic [$clog2(mem_words)-1:0] core_addr;
  logic core_we;

  assign core_addr = tmp0[$clog2(mem_words)+1:2]; // Word index from byte address.
  assign core_we = (in_plane == in_mmu) && !boot_we; // Boot port wins.
  assign mem_rdata = mem[core_addr]; // Asynchronous read.

  always_ff @(posedge clk) begin
    if (boot_we) begin
      mem[boot_addr] <= boot_data;
    end else if (core_we) begin
      mem[core_addr] <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      store_valid <= 1'b0;
    end else begin
      store_valid <= core_we; // One pulse per store.
    end
  end

  always_ff @(posedge clk) begin
    if (core_we) begin
      store_addr <= tmp0;
      store_data <= bus;
    end
  end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/100ps

module cpu_top
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic boot_we,
  input logic [$clog2(mem_words)-1:0] boot_addr,
  input logic [word_width-1:0] boot_data,
  input logic booted,
  output logic store_valid,
  output logic [word_width-1:0] store_addr,
  output logic [word_width-1:0] store_data
);

  opcode_e opcode;
  logic [uop_count_width-1:0] uop_count;
  logic [ctrl_data_width-1:0] ctrl_data;
  reg_sel_e reg_sel;
  out_plane_e out_plane;
  in_plane_e in_plane;
  logic uop_reset;
  mlu_op_e mlu_op;
  shifter_op_e shifter_op;
  opcode_sel_e opcode_sel;
  logic [word_width-1:0] bus;
  logic [word_width-1:0] opword;
  logic [word_width-1:0] rd_data;
  logic [word_width-1:0] tmp0;
  logic [word_width-1:0] mem_rdata;

  microcode u_microcode (
    .opcode(opcode), .uop_count(uop_count), .ctrl_data(ctrl_data), .reg_sel(reg_sel),
    .out_plane(out_plane), .in_plane(in_plane), .uop_reset(uop_reset),
    .mlu_op(mlu_op), .shifter_op(shifter_op), .opcode_sel(opcode_sel)
  );

  control_logic u_control_logic (
    .clk(clk), .rst(rst), .booted(booted), .bus(bus), .in_plane(in_plane),
    .uop_reset(uop_reset), .opcode_sel(opcode_sel), .opcode(opcode),
    .uop_count(uop_count), .opword(opword)
  );

  register_file u_register_file (
    .clk(clk), .rst(rst), .reg_sel(reg_sel), .ctrl_data(ctrl_data), .opword(opword),
    .in_plane(in_plane), .bus(bus), .rd_data(rd_data)
  );

  datapath u_datapath (
    .clk(clk), .rst(rst), .out_plane(out_plane), .in_plane(in_plane), .mlu_op(mlu_op),
    .shifter_op(shifter_op), .ctrl_data(ctrl_data), .opword(opword), .rd_data(rd_data),
    .mem_rdata(mem_rdata), .bus(bus), .tmp0(tmp0)
  );

  memory u_memory (
    .clk(clk), .rst(rst), .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
    .tmp0(tmp0), .bus(bus), .in_plane(in_plane), .mem_rdata(mem_rdata),
    .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
  );

  // The host raises booted once and keeps it high.
  assert property (@(posedge clk) disable iff (rst) !$fell(booted))
    else $error("Boot signal fell while the core was running");

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

  localparam int vec_depth = 512; // Vector file capacity in words.
  localparam int reset_cycles = 3;

  logic clk;
  logic rst;
  logic boot_we;
  logic [7:0] boot_addr;
  logic [31:0] boot_data;
  logic booted;
  logic store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;

  logic [31:0] vec [vec_depth]; // Length, program, store count, then address/data pairs.
  int prog_len;
  int store_count;
  int cycle_count;
  int cycle_limit;

  cpu_top u_dut (
    .clk(clk), .rst(rst), .boot_we(boot_we), .boot_addr(boot_addr),
    .boot_data(boot_data), .booted(booted), .store_valid(store_valid),
    .store_addr(store_addr), .store_data(store_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // One write strobe per program word before the core is released.
  task automatic boot_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      boot_we <= 1'b1;
      boot_addr <= 8'(i); // Word index.
      boot_data <= vec[1 + i];
    end
    @(posedge clk);
    boot_we <= 1'b0;
    booted <= 1'b1; // Core starts its reset sequence.
  endtask

  // Wait for the next store pulse and compare it with pair n.
  task automatic check_store(input int n);
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    exp_addr = vec[prog_len + 2 + 2 * n];
    exp_data = vec[prog_len + 3 + 2 * n];
    @(negedge clk); // Registered outputs are stable here.
    while (store_valid !== 1'b1) begin
      @(negedge clk);
    end
    assert (store_addr === exp_addr)
      else stop_with_error($sformatf("FAILED at %0d ns: store %0d address %h, expected %h",
                                     $time, n, store_addr, exp_addr));
    assert (store_data === exp_data)
      else stop_with_error($sformatf("FAILED at %0d ns: store %0d data %h, expected %h",
                                     $time, n, store_data, exp_data));
  endtask

  // Run limit.
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_with_error($sformatf("Timeout after %0d cycles, the core did not produce all stores",
                                cycle_count));
    end
  end

  initial begin
    rst = 1'b1;
    boot_we = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    booted = 1'b0; // Core held in reset opcode while loading.
    cycle_count = 0;
    cycle_limit = 1000; // Replaced once the vectors are read.
    $readmemh("tests/cpu_vectors.txt", vec);
    assert (!$isunknown(vec[0]) && vec[0] > 0 && vec[0] <= 256)
      else stop_with_error("Vector file is missing or holds no valid program length");
    prog_len = int'(vec[0]);
    assert (!$isunknown(vec[prog_len + 1]) && vec[prog_len + 1] > 0)
      else stop_with_error("Vector file lists no expected stores");
    store_count = int'(vec[prog_len + 1]);
    assert (prog_len + 2 + 2 * store_count <= vec_depth)
      else stop_with_error("Vector file is larger than the testbench can hold");
    cycle_limit = prog_len * 9 + (reset_cycles + prog_len + 1) + 20; // Nine cycles per word.
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    boot_program();
    for (int n = 0; n < store_count; n++) begin
      check_store(n);
    end
    $display("Checked %0d stores in %0d cycles", store_count, cycle_count);
    $display("No errors");
    $finish;
  end

endmodule

// File: build.f
source/cpu_pkg.sv
source/microcode.sv
source/control_logic.sv
source/register_file.sv
source/datapath.sv
source/memory.sv
source/cpu_top.sv
tests/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_microcoded

sources:
  - files:
      - source/cpu_pkg.sv
      - source/microcode.sv
      - source/control_logic.sv
      - source/register_file.sv
      - source/datapath.sv
      - source/memory.sv
      - source/cpu_top.sv
  - target: test
    files:
      - tests/cpu_tb.sv

// File: tests/cpu_vectors.txt
// Program length, program words (op 31:26, rD 25:21, rS/rA 20:16, rB 15:11, imm 15:0),
// store count, then expected store address and data per line.
00000011
08200200 // lhu r1, 0x0200
08401234 // lhu r2, 0x1234
14220000 // sw [r1], r2
08600204 // lhu r3, 0x0204
1C808765 // lh r4, 0x8765
14640000 // sw [r3], r4
0CA20F00 // addu r5, r2, 0x0F00
0CC10008 // addu r6, r1, 8
14C50000 // sw [r6], r5
08E0F0F0 // lhu r7, 0xF0F0
11023800 // add r8, r2, r7
0D260004 // addu r9, r6, 4
15280000 // sw [r9], r8
19423800 // or r10, r2, r7
FC000000 // undefined opcode 63, skipped
0D690004 // addu r11, r9, 4
156A0000 // sw [r11], r10
00000005
00000200 00001234 // lhu zero-extended
00000204 FFFF8765 // lh sign-extended
00000208 00002134 // 0x1234 + 0x0F00
0000020C 00010324 // 0x1234 + 0xF0F0
00000210 0000F2F4 // 0x1234 | 0xF0F0
